/* verilog/fdiv_pkg.sv */
package fdiv_pkg;

    localparam int MANT_W = 53;
    localparam int OPND_W = 58;
    localparam int PROD_W = 116;
    localparam int QUOT_W = 57;
    localparam int SP_PAD = 29;               // Low bits unused in single precision.

    localparam logic [1:0] OPA_FA = 2'd0;
    localparam logic [1:0] OPA_X  = 2'd1;
    localparam logic [1:0] OPA_A  = 2'd2;
    localparam logic [1:0] OPA_FB = 2'd3;
    localparam logic [1:0] OPB_FB = 2'd0;
    localparam logic [1:0] OPB_X  = 2'd1;
    localparam logic [1:0] OPB_Q  = 2'd2;

    typedef enum logic [3:0] {
        IDLE, LOOKUP, NEWTON1, NEWTON2, NEWTON3, NEWTON4,
        QUOT1, QUOT2, QUOT3, QUOT4, SELECT, ROUND1, ROUND2
    } div_state_t;

    typedef struct packed {
        logic [QUOT_W-3:0] quot;              // 1.54 truncated quotient.
        logic              guard;
        logic              sticky;
    } quot_dp_t;

    typedef struct packed {
        logic [25:0]       quot;
        logic              guard;
        logic              sticky;
        logic [SP_PAD-1:0] pad;
    } quot_sp_t;

    typedef union packed {
        quot_dp_t dp;
        quot_sp_t sp;
    } quot_word_u;

    // One unit in the last place of the 57-bit quotient word.
    function automatic logic [QUOT_W-1:0] quot_ulp(input logic db);
        return db ? QUOT_W'(1) : (QUOT_W'(1) << SP_PAD);
    endfunction

endpackage

/* verilog/recip_seed_rom.sv */
`timescale 1ns/1ps

module recip_seed_rom (
    input  logic [7:0] addr,
    output logic [7:0] seed
);

    typedef logic [7:0] seed_tab_t [256];

    // Fraction bits of 512/(256 + a + 0.5), i.e. 262144/(513 + 2a) - 256.
    function automatic seed_tab_t build_table();
        seed_tab_t   tab;
        int unsigned quo;
        for (int a = 0; a < 256; a++) begin
            quo    = 262144 / (513 + 2 * a);
            tab[a] = 8'(quo - 256);
        end
        return tab;
    endfunction

    localparam seed_tab_t SEED_TABLE = build_table();

    assign seed = SEED_TABLE[addr];

endmodule

/* verilog/nr_div_controller.sv */
`timescale 1ns/1ps

module nr_div_controller
    import fdiv_pkg::*;
#(
    parameter int NR_ITERS_DB = 3,
    parameter int NR_ITERS_SP = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fdiv,
    input  logic       db,
    output div_state_t state,
    output logic [1:0] opa_sel,
    output logic [1:0] opb_sel,
    output logic       op_load,
    output logic       seed_load,
    output logic       x_load,
    output logic       a_load,
    output logic       q_load,
    output logic       eb_load,
    output logic       fq_load,
    output logic       q_valid
);

    localparam int ITER_MAX = (NR_ITERS_DB > NR_ITERS_SP) ? NR_ITERS_DB : NR_ITERS_SP;
    localparam int CNT_W    = (ITER_MAX > 1) ? $clog2(ITER_MAX) : 1;

    div_state_t       next_state;
    logic [CNT_W-1:0] iter_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iter_cnt <= '0;
        end else if (state == LOOKUP) begin
            iter_cnt <= db ? CNT_W'(NR_ITERS_DB - 1) : CNT_W'(NR_ITERS_SP - 1);
        end else if (state == NEWTON4 && iter_cnt != '0) begin
            iter_cnt <= iter_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= (state == ROUND2);  // fq lands on the same edge.
        end
    end

    always_comb begin
        next_state = state;
        opa_sel    = OPA_FA;
        opb_sel    = OPB_FB;
        op_load    = 1'b0;
        seed_load  = 1'b0;
        x_load     = 1'b0;
        a_load     = 1'b0;
        q_load     = 1'b0;
        eb_load    = 1'b0;
        fq_load    = 1'b0;
        case (state)
            IDLE: begin
                if (fdiv) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                seed_load  = 1'b1;
                next_state = NEWTON1;
            end
            NEWTON1: begin
                op_load    = 1'b1;   // x * fb.
                opa_sel    = OPA_X;
                opb_sel    = OPB_FB;
                next_state = NEWTON2;
            end
            NEWTON2: begin
                a_load     = 1'b1;
                next_state = NEWTON3;
            end
            NEWTON3: begin
                op_load    = 1'b1;   // x * (2 - x*fb).
                opa_sel    = OPA_A;
                opb_sel    = OPB_X;
                next_state = NEWTON4;
            end
            NEWTON4: begin
                x_load     = 1'b1;
                next_state = (iter_cnt == '0) ? QUOT1 : NEWTON1;
            end
            QUOT1: begin
                op_load    = 1'b1;
                opa_sel    = OPA_FA;
                opb_sel    = OPB_X;
                next_state = QUOT2;
            end
            QUOT2: begin
                q_load     = 1'b1;
                next_state = QUOT3;
            end
            QUOT3: begin
                op_load    = 1'b1;   // Back product q * fb.
                opa_sel    = OPA_FB;
                opb_sel    = OPB_Q;
                next_state = QUOT4;
            end
            QUOT4: begin
                eb_load    = 1'b1;
                next_state = SELECT;
            end
            SELECT: begin
                next_state = ROUND1;
            end
            ROUND1: begin
                next_state = ROUND2;
            end
            ROUND2: begin
                fq_load    = 1'b1;
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

/* verilog/mant_mul_unit.sv */
`timescale 1ns/1ps

module mant_mul_unit
    import fdiv_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [MANT_W-1:0] fa,
    input  logic [MANT_W-1:0] fb,
    input  logic [OPND_W-1:0] x_val,
    input  logic [OPND_W-1:0] a_val,
    input  logic [OPND_W-1:0] q_val,
    input  logic [1:0]        opa_sel,
    input  logic [1:0]        opb_sel,
    input  logic              op_load,
    output logic [PROD_W-1:0] product
);

    logic [OPND_W-1:0] fa_ext;
    logic [OPND_W-1:0] fb_ext;
    logic [OPND_W-1:0] opa_mux;
    logic [OPND_W-1:0] opb_mux;
    logic [OPND_W-1:0] opa_r;
    logic [OPND_W-1:0] opb_r;

    assign fa_ext = {fa, 5'b0};  // Five guard bits.
    assign fb_ext = {fb, 5'b0};

    always_comb begin
        case (opa_sel)
            OPA_X:   opa_mux = x_val;
            OPA_A:   opa_mux = a_val;
            OPA_FB:  opa_mux = fb_ext;
            default: opa_mux = fa_ext;
        endcase
    end

    always_comb begin
        case (opb_sel)
            OPB_X:   opb_mux = x_val;
            OPB_Q:   opb_mux = q_val;
            default: opb_mux = fb_ext;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opa_r <= '0;
            opb_r <= '0;
        end else if (op_load) begin
            opa_r <= opa_mux;
            opb_r <= opb_mux;
        end
    end

    // Multiplier sees only registered operands, product valid the next cycle.
    assign product = PROD_W'(opa_r) * PROD_W'(opb_r);

endmodule

/* verilog/nr_iterate_regs.sv */
`timescale 1ns/1ps

module nr_iterate_regs
    import fdiv_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              db,
    input  logic [7:0]        seed,
    input  logic [PROD_W-1:0] product,
    input  logic              seed_load,
    input  logic              x_load,
    input  logic              a_load,
    input  logic              q_load,
    input  logic              eb_load,
    output logic [OPND_W-1:0] x_val,
    output logic [OPND_W-1:0] a_val,
    output logic [OPND_W-1:0] q_val,
    output logic [PROD_W-1:0] eb_val
);

    localparam int QE_W = QUOT_W - 1;

    logic [OPND_W-1:0] prod_hi;
    logic [QE_W-1:0]   q_est;
    logic [QE_W-1:0]   q_masked;
    logic [QUOT_W-1:0] q_next;

    // Product bit PROD_W-2 carries weight one.
    assign prod_hi = product[PROD_W-2 -: OPND_W];
    assign q_est   = product[PROD_W-2 -: QE_W];

    always_comb begin
        if (db) begin
            q_masked = q_est;
        end else begin
            q_masked = {q_est[QE_W-1:SP_PAD], {SP_PAD{1'b0}}};
        end
    end

    // Estimate is never high, so bias up by one ulp.
    assign q_next = {1'b0, q_masked} + quot_ulp(db);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_val  <= '0;
            a_val  <= '0;
            q_val  <= '0;
            eb_val <= '0;
        end else begin
            if (seed_load) begin
                x_val <= {2'b01, seed, {(OPND_W - 10){1'b0}}};
            end else if (x_load) begin
                x_val <= prod_hi;
            end
            if (a_load) begin
                a_val <= ~prod_hi;  // 2 - x*fb.
            end
            if (q_load) begin
                q_val <= {q_next, 1'b0};
            end
            if (eb_load) begin
                eb_val <= product;
            end
        end
    end

endmodule

/* verilog/quot_select_round.sv */
`timescale 1ns/1ps

module quot_select_round
    import fdiv_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [MANT_W-1:0] fa,
    input  logic [MANT_W-1:0] fb,
    input  logic              db,
    input  logic [OPND_W-1:0] q_val,
    input  logic [PROD_W-1:0] eb_val,
    input  logic              fq_load,
    output quot_word_u        fq
);

    localparam int REM_W = PROD_W + 1;
    localparam int FA_SH = PROD_W - MANT_W - 2;
    localparam int FB_SH = OPND_W - MANT_W + 1;

    logic [REM_W-1:0]  rem;
    logic [REM_W-1:0]  fb_step;
    logic [REM_W-1:0]  rem_sel;
    logic [QUOT_W-1:0] q_cand;
    logic [QUOT_W-1:0] q_sel;
    logic              rem_neg;
    logic              sticky;
    quot_word_u        fq_next;

    assign q_cand = q_val[OPND_W-1:1];

    // fa aligned to the back product scale.
    assign rem     = (REM_W'(fa) << FA_SH) - REM_W'(eb_val);
    assign fb_step = db ? (REM_W'(fb) << FB_SH) : (REM_W'(fb) << (FB_SH + SP_PAD));
    assign rem_neg = rem[REM_W-1];

    assign rem_sel = rem_neg ? rem + fb_step : rem;
    assign q_sel   = rem_neg ? q_cand - quot_ulp(db) : q_cand;

    assign sticky = |rem_sel;  // Inexact.

    always_comb begin
        fq_next = '0;
        if (db) begin
            fq_next.dp.quot   = q_sel[QUOT_W-2:1];
            fq_next.dp.guard  = q_sel[0];
            fq_next.dp.sticky = sticky;
        end else begin
            fq_next.sp.quot   = q_sel[QUOT_W-2:SP_PAD+1];
            fq_next.sp.guard  = q_sel[SP_PAD];
            fq_next.sp.sticky = sticky;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fq <= '0;
        end else if (fq_load) begin
            fq <= fq_next;
        end
    end

endmodule

/* verilog/fdiv_mantissa_top.sv */
`timescale 1ns/1ps

module fdiv_mantissa_top
    import fdiv_pkg::*;
#(
    parameter int NR_ITERS_DB = 3,
    parameter int NR_ITERS_SP = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [MANT_W-1:0] fa,
    input  logic [MANT_W-1:0] fb,
    input  logic              db,
    input  logic              fdiv,
    output quot_word_u        fq,
    output logic              q_valid
);

    div_state_t        state;
    logic [1:0]        opa_sel;
    logic [1:0]        opb_sel;
    logic              op_load;
    logic              seed_load;
    logic              x_load;
    logic              a_load;
    logic              q_load;
    logic              eb_load;
    logic              fq_load;
    logic [7:0]        seed;
    logic [PROD_W-1:0] product;
    logic [OPND_W-1:0] x_val;
    logic [OPND_W-1:0] a_val;
    logic [OPND_W-1:0] q_val;
    logic [PROD_W-1:0] eb_val;

    nr_div_controller #(
        .NR_ITERS_DB(NR_ITERS_DB),
        .NR_ITERS_SP(NR_ITERS_SP)
    ) u_ctrl (
        .clk(clk), .rst_n(rst_n), .fdiv(fdiv), .db(db), .state(state),
        .opa_sel(opa_sel), .opb_sel(opb_sel), .op_load(op_load),
        .seed_load(seed_load), .x_load(x_load), .a_load(a_load),
        .q_load(q_load), .eb_load(eb_load), .fq_load(fq_load), .q_valid(q_valid)
    );

    recip_seed_rom u_rom (
        .addr(fb[MANT_W-2 -: 8]),  // Leading fraction bits.
        .seed(seed)
    );

    mant_mul_unit u_mul (
        .clk(clk), .rst_n(rst_n), .fa(fa), .fb(fb),
        .x_val(x_val), .a_val(a_val), .q_val(q_val),
        .opa_sel(opa_sel), .opb_sel(opb_sel), .op_load(op_load), .product(product)
    );

    nr_iterate_regs u_iter (
        .clk(clk), .rst_n(rst_n), .db(db), .seed(seed), .product(product),
        .seed_load(seed_load), .x_load(x_load), .a_load(a_load),
        .q_load(q_load), .eb_load(eb_load),
        .x_val(x_val), .a_val(a_val), .q_val(q_val), .eb_val(eb_val)
    );

    quot_select_round u_sel (
        .clk(clk), .rst_n(rst_n), .fa(fa), .fb(fb), .db(db),
        .q_val(q_val), .eb_val(eb_val), .fq_load(fq_load), .fq(fq)
    );

endmodule

/* verification/tb_fdiv_vectors.svh */
`ifndef TB_FDIV_VECTORS_SVH
`define TB_FDIV_VECTORS_SVH

// Columns are fa, fb and db, where db is 1 for double and 0 for single.
localparam int NUM_DIRECTED = 18;

localparam logic [2*MANT_W:0] DIR_VEC [NUM_DIRECTED] = '{
    {53'h10000000000000, 53'h10000000000000, 1'b1},  // Equal operands.
    {53'h1A5A5A5A5A5A5A, 53'h1A5A5A5A5A5A5A, 1'b1},
    {53'h10000000000000, 53'h1FFFFFFFFFFFFF, 1'b1},  // Maximum divisor.
    {53'h1FFFFFFFFFFFFF, 53'h10000000000000, 1'b1},  // Minimum divisor.
    {53'h1FFFFFFFFFFFFE, 53'h1FFFFFFFFFFFFF, 1'b1},  // Near one, below.
    {53'h10000000000000, 53'h10000000000001, 1'b1},
    {53'h18000000000000, 53'h10000000000000, 1'b1},  // Exact 1.5.
    {53'h10000000000000, 53'h18000000000000, 1'b1},  // 2/3.
    {53'h1E000000000000, 53'h14000000000000, 1'b1},
    {53'h10000000000000, 53'h1C000000000000, 1'b1},  // 4/7.
    {53'h1921FB54442D18, 53'h15BF0A8B145769, 1'b1},
    {53'h10000000000000, 53'h10000000000000, 1'b0},
    {53'h1FFFFFE0000000, 53'h10000000000000, 1'b0},  // Minimum divisor.
    {53'h10000000000000, 53'h1FFFFFE0000000, 1'b0},  // Maximum divisor.
    {53'h1FFFFFC0000000, 53'h1FFFFFE0000000, 1'b0},  // Near one.
    {53'h10000000000000, 53'h18000000000000, 1'b0},
    {53'h1E000000000000, 53'h14000000000000, 1'b0},  // Exact 1.5.
    {53'h1921FB60000000, 53'h15BF0A80000000, 1'b0}
};

`endif

/* verification/tb_fdiv_mantissa.sv */
`timescale 1ns/1ps

module tb_fdiv_mantissa import fdiv_pkg::*; ();

    `include "tb_fdiv_vectors.svh"

    localparam int NR_DB       = 3;
    localparam int NR_SP       = 2;
    localparam int NUM_RANDOM  = 40;
    localparam int NUM_ENTRIES = NUM_DIRECTED + NUM_RANDOM;
    localparam int MAX_WAIT    = 30;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 30 + 100;

    logic              clk;
    logic              rst_n;
    logic [MANT_W-1:0] fa;
    logic [MANT_W-1:0] fb;
    logic              db;
    logic              fdiv;
    quot_word_u        fq;
    logic              q_valid;

    logic [MANT_W-1:0] tab_fa [NUM_ENTRIES];
    logic [MANT_W-1:0] tab_fb [NUM_ENTRIES];
    logic              tab_db [NUM_ENTRIES];
    quot_word_u        tab_fq [NUM_ENTRIES];
    int                tab_cycles [NUM_ENTRIES];

    int error_count;
    int check_count;
    int cycle_count;

    fdiv_mantissa_top #(
        .NR_ITERS_DB(NR_DB),
        .NR_ITERS_SP(NR_SP)
    ) DUT (
        .clk(clk), .rst_n(rst_n), .fa(fa), .fb(fb), .db(db), .fdiv(fdiv),
        .fq(fq), .q_valid(q_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: simulation ran %0d cycles without finishing", cycle_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // Exact quotient by long division, truncated to the output grid.
    function automatic quot_word_u model_quotient(input logic [MANT_W-1:0] a,
                                                  input logic [MANT_W-1:0] b,
                                                  input logic dbl);
        logic [127:0] num;
        logic [127:0] quo;
        logic [127:0] rem;
        quot_word_u   res;
        res = '0;
        num = dbl ? ({75'b0, a} << 55) : ({75'b0, a} << 26);
        quo = num / {75'b0, b};
        rem = num % {75'b0, b};
        if (dbl) begin
            res.dp.quot   = quo[55:1];
            res.dp.guard  = quo[0];
            res.dp.sticky = (rem != '0);
        end else begin
            res.sp.quot   = quo[26:1];
            res.sp.guard  = quo[0];
            res.sp.sticky = (rem != '0);
        end
        return res;
    endfunction

    // Lookup, Newton passes, quotient passes, select, round, q_valid cycle.
    function automatic int expected_latency(input logic dbl);
        int iters;
        iters = dbl ? NR_DB : NR_SP;
        return 1 + 4 * iters + 4 + 1 + 2 + 1;
    endfunction

    function automatic logic [MANT_W-1:0] random_mant(input logic dbl);
        logic [63:0]       raw;
        logic [MANT_W-1:0] m;
        raw = {$urandom, $urandom};
        m = raw[MANT_W-1:0];
        m[MANT_W-1] = 1'b1;  // Hidden bit.
        if (!dbl) begin
            m[SP_PAD-1:0] = '0;
        end
        return m;
    endfunction

    task automatic build_table();
        for (int i = 0; i < NUM_DIRECTED; i++) begin
            tab_fa[i] = DIR_VEC[i][2*MANT_W -: MANT_W];
            tab_fb[i] = DIR_VEC[i][MANT_W -: MANT_W];
            tab_db[i] = DIR_VEC[i][0];
        end
        for (int i = NUM_DIRECTED; i < NUM_ENTRIES; i++) begin
            tab_db[i] = (i % 2 == 0);
            tab_fa[i] = random_mant(tab_db[i]);
            tab_fb[i] = random_mant(tab_db[i]);
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            tab_fq[i]     = model_quotient(tab_fa[i], tab_fb[i], tab_db[i]);
            tab_cycles[i] = expected_latency(tab_db[i]);
        end
    endtask

    // Called on a falling edge, returns on a falling edge with the unit idle.
    task automatic run_entry(input int idx);
        int   cycles;
        logic busy_pulse;
        busy_pulse = (idx % 3 == 1);  // Extra start while busy.
        fa     = tab_fa[idx];
        fb     = tab_fb[idx];
        db     = tab_db[idx];
        fdiv   = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            fdiv = busy_pulse && (cycles == 5);
        end while (!q_valid && cycles < MAX_WAIT);
        check_count++;
        if (q_valid !== 1'b1) begin
            error_count++;
            $display("Entry %0d: q_valid never rose within %0d cycles", idx, MAX_WAIT);
            return;
        end
        check_count++;
        if (cycles != tab_cycles[idx]) begin
            error_count++;
            $display("ERROR t=%0t q_valid latency: expected %0d, got %0d",
                     $time, tab_cycles[idx], cycles);
        end
        check_count++;
        if (fq !== tab_fq[idx]) begin
            error_count++;
            $display("ERROR t=%0t fq: expected %h, got %h", $time, tab_fq[idx], fq);
        end
        if (!tab_db[idx]) begin
            check_count++;
            if (fq.sp.pad !== '0) begin
                error_count++;
                $display("ERROR t=%0t fq.sp.pad: expected %h, got %h",
                         $time, {SP_PAD{1'b0}}, fq.sp.pad);
            end
        end
        @(negedge clk);
        check_count++;
        if (q_valid !== 1'b0) begin
            error_count++;
            $display("ERROR t=%0t q_valid: expected %b, got %b", $time, 1'b0, q_valid);
        end
        check_count++;
        if (fq !== tab_fq[idx]) begin
            error_count++;
            $display("ERROR t=%0t fq held: expected %h, got %h", $time, tab_fq[idx], fq);
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        void'($urandom(27270));
        rst_n = 1'b0;
        fa    = '0;
        fb    = '0;
        db    = 1'b0;
        fdiv  = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_count++;
            if (q_valid !== 1'b0) begin
                error_count++;
                $display("ERROR t=%0t q_valid: expected %b, got %b", $time, 1'b0, q_valid);
            end
            check_count++;
            if (fq !== '0) begin
                error_count++;
                $display("ERROR t=%0t fq: expected %h, got %h", $time, {QUOT_W{1'b0}}, fq);
            end
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        repeat (2) @(negedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+verification
verilog/fdiv_pkg.sv
verilog/recip_seed_rom.sv
verilog/nr_div_controller.sv
verilog/mant_mul_unit.sv
verilog/nr_iterate_regs.sv
verilog/quot_select_round.sv
verilog/fdiv_mantissa_top.sv
verification/tb_fdiv_mantissa.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_fdiv_mantissa \
    -f compile.f -o sim_fdiv_mantissa
output=$(./obj_dir/sim_fdiv_mantissa)
echo "$output"
if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi
